//--- verilog/i2c_cfg_pkg.sv
package i2c_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths with a meaning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0]  i2c_byte_t;     // one byte on the bus.
    typedef logic [6:0]  dev_addr_t;     // 7-bit slave address.
    typedef logic [23:0] cfg_word_t;     // {pad, dev, reg, data}.
    typedef logic [31:0] wb_data_t;
    typedef logic [5:0]  wb_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host decode and table size
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam wb_addr_t  CFG_REG_ADDR  = 6'h3d;
    localparam i2c_byte_t CFG_WRITE_CMD = 8'h06;
    localparam int        INIT_COUNT    = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machines and shifter operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        ST_IDLE, ST_LOAD, ST_START, ST_ADDR, ST_REG, ST_DATA, ST_STOP, ST_ABORT
    } txn_state_t;

    typedef enum logic [1:0] {
        OP_START, OP_BYTE, OP_STOP
    } shift_op_t;

endpackage

//--- verilog/i2c_init_table.sv
`timescale 1ns/100ps

module i2c_init_table (
    input  logic [2:0]             init_index_i,
    output i2c_cfg_pkg::cfg_word_t init_word_o
);

localparam i2c_cfg_pkg::dev_addr_t CODEC_ADDR = 7'h1a;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power-up sequence for the codec
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_comb begin
    case (init_index_i)
        3'd0:    init_word_o = {1'b0, CODEC_ADDR, 8'h1e, 8'h00};  // soft reset.
        3'd1:    init_word_o = {1'b0, CODEC_ADDR, 8'h0c, 8'h10};  // power down outputs only.
        3'd2:    init_word_o = {1'b0, CODEC_ADDR, 8'h0e, 8'h02};  // i2s, 16 bit.
        3'd3:    init_word_o = {1'b0, CODEC_ADDR, 8'h10, 8'h00};  // normal mode sampling.
        3'd4:    init_word_o = {1'b0, CODEC_ADDR, 8'h08, 8'h12};  // dac select, mic muted.
        3'd5:    init_word_o = {1'b0, CODEC_ADDR, 8'h0a, 8'h00};  // no de-emphasis.
        3'd6:    init_word_o = {1'b0, CODEC_ADDR, 8'h00, 8'h17};  // line in at 0 dB.
        3'd7:    init_word_o = {1'b0, CODEC_ADDR, 8'h12, 8'h01};  // activate interface.
        default: init_word_o = '0;
    endcase
end

endmodule

//--- verilog/i2c_host_port.sv
`timescale 1ns/100ps

module i2c_host_port (
    input  logic                   clock_76p8_mhz,
    input  logic                   reset_i,
    input  i2c_cfg_pkg::wb_addr_t  wbs_adr_i,
    input  i2c_cfg_pkg::wb_data_t  wbs_dat_i,
    input  logic                   wbs_we_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_cyc_i,
    output logic                   wbs_ack_o,
    input  logic                   host_take_i,
    output logic                   host_pend_o,
    output i2c_cfg_pkg::cfg_word_t host_word_o
);

logic accept;

// a held-off write goes in on the same cycle the old one is taken.
assign accept = wbs_cyc_i && wbs_stb_i && wbs_we_i && !wbs_ack_o
                && (wbs_adr_i == i2c_cfg_pkg::CFG_REG_ADDR)
                && (wbs_dat_i[31:24] == i2c_cfg_pkg::CFG_WRITE_CMD)
                && (!host_pend_o || host_take_i);

always_ff @(posedge clock_76p8_mhz) begin
    if (reset_i) begin
        wbs_ack_o   <= 1'b0;
        host_pend_o <= 1'b0;
    end else begin
        wbs_ack_o <= accept;                // single pulse, strobe still high after it.
        if (accept) begin
            host_pend_o <= 1'b1;
        end else if (host_take_i) begin
            host_pend_o <= 1'b0;
        end
    end
end

// one-entry holding register.
always_ff @(posedge clock_76p8_mhz) begin
    if (accept) begin
        host_word_o <= wbs_dat_i[23:0];
    end
end

endmodule

//--- verilog/i2c_bit_timer.sv
`timescale 1ns/100ps

module i2c_bit_timer #(
    parameter int PRESCALE = 48
) (
    input  logic clock_76p8_mhz,
    input  logic reset_i,
    input  logic tick_en_i,
    output logic tick_o
);

localparam int CW = $clog2(PRESCALE + 1);
localparam logic [CW-1:0] RELOAD = CW'(PRESCALE - 1);

logic [CW-1:0] count;
logic          tick_q;

// a tick left over from the last enabled cycle never leaks out.
assign tick_o = tick_q && tick_en_i;

always_ff @(posedge clock_76p8_mhz) begin
    if (reset_i || !tick_en_i) begin
        count  <= RELOAD;                   // restart on every enable.
        tick_q <= 1'b0;
    end else if (count == '0) begin
        count  <= RELOAD;
        tick_q <= 1'b1;
    end else begin
        count  <= count - 1'b1;
        tick_q <= 1'b0;
    end
end

endmodule

//--- verilog/i2c_byte_shifter.sv
`timescale 1ns/100ps

module i2c_byte_shifter (
    input  logic                   clock_76p8_mhz,
    input  logic                   reset_i,
    input  logic                   op_req_i,
    input  i2c_cfg_pkg::shift_op_t op_i,
    input  i2c_cfg_pkg::i2c_byte_t tx_byte_i,
    output logic                   op_ack_o,
    output logic                   got_nack_o,
    output logic                   tick_en_o,
    input  logic                   tick_i,
    input  logic                   scl_i,
    output logic                   scl_t_o,
    input  logic                   sda_i,
    output logic                   sda_t_o
);

typedef enum logic [1:0] {SH_IDLE, SH_RUN, SH_ACK} sh_state_t;

sh_state_t              state;
i2c_cfg_pkg::shift_op_t op_q;
i2c_cfg_pkg::i2c_byte_t shift_q;
logic [1:0]             qph;            // quarter of the current bit.
logic [3:0]             bitn;           // 8 is the acknowledge bit.
logic                   scl_lvl;
logic                   sda_lvl;
logic                   last_q;
logic                   ack_bit;

assign tick_en_o = (state == SH_RUN);
assign ack_bit   = (op_q == i2c_cfg_pkg::OP_BYTE) && (bitn == 4'd8);
assign last_q    = (qph == 2'd3) && ((op_q != i2c_cfg_pkg::OP_BYTE) || ack_bit);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line levels per quarter, 1 is released
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_comb begin
    case (op_q)
        i2c_cfg_pkg::OP_START: begin
            scl_lvl = (qph != 2'd3);
            sda_lvl = (qph < 2'd2);             // falls while scl is high.
        end
        i2c_cfg_pkg::OP_STOP: begin
            scl_lvl = (qph != 2'd0);
            sda_lvl = (qph >= 2'd2);            // rises while scl is high.
        end
        default: begin
            scl_lvl = (qph == 2'd1) || (qph == 2'd2);
            sda_lvl = ack_bit || shift_q[7];    // msb first, let go for the ack.
        end
    endcase
end

always_ff @(posedge clock_76p8_mhz) begin
    if (reset_i) begin
        state      <= SH_IDLE;
        qph        <= '0;
        bitn       <= '0;
        op_ack_o   <= 1'b0;
        got_nack_o <= 1'b0;
        scl_t_o    <= 1'b1;
        sda_t_o    <= 1'b1;
    end else begin
        case (state)
            SH_IDLE: begin
                if (op_req_i) begin
                    qph        <= '0;
                    bitn       <= '0;
                    got_nack_o <= 1'b0;
                    state      <= SH_RUN;
                end
            end
            SH_RUN: begin
                scl_t_o <= scl_lvl;
                sda_t_o <= sda_lvl;
                if (tick_i) begin
                    qph <= qph + 2'd1;
                    // mid high phase of the ninth clock.
                    if (ack_bit && qph == 2'd1) begin
                        got_nack_o <= sda_i || !scl_i;
                    end
                    if (last_q) begin
                        op_ack_o <= 1'b1;
                        state    <= SH_ACK;
                    end else if (qph == 2'd3) begin
                        bitn <= bitn + 4'd1;
                    end
                end
            end
            default: begin
                if (!op_req_i) begin
                    op_ack_o <= 1'b0;
                    state    <= SH_IDLE;
                end
            end
        endcase
    end
end

always_ff @(posedge clock_76p8_mhz) begin
    if (state == SH_IDLE && op_req_i) begin
        op_q    <= op_i;
        shift_q <= tx_byte_i;
    end else if (state == SH_RUN && tick_i && qph == 2'd3) begin
        shift_q <= {shift_q[6:0], 1'b0};
    end
end

endmodule

//--- verilog/i2c_txn_fsm.sv
`timescale 1ns/100ps

module i2c_txn_fsm (
    input  logic                   clock_76p8_mhz,
    input  logic                   reset_i,
    input  logic                   init_start_i,
    input  logic                   host_pend_i,
    input  i2c_cfg_pkg::cfg_word_t host_word_i,
    output logic                   host_take_o,
    output logic [2:0]             init_index_o,
    input  i2c_cfg_pkg::cfg_word_t init_word_i,
    output logic                   op_req_o,
    output i2c_cfg_pkg::shift_op_t op_o,
    output i2c_cfg_pkg::i2c_byte_t tx_byte_o,
    input  logic                   op_ack_i,
    input  logic                   got_nack_i,
    output logic                   busy_o,
    output logic                   nack_o
);

i2c_cfg_pkg::txn_state_t state;
i2c_cfg_pkg::cfg_word_t  word_q;
i2c_cfg_pkg::dev_addr_t  dev_addr;
logic                    init_active;
logic                    src_host;
logic                    op_done;

assign dev_addr    = word_q[22:16];
assign op_done     = op_req_o && op_ack_i;
assign host_take_o = (state == i2c_cfg_pkg::ST_LOAD) && src_host;  // word is copied here.

// op and byte follow the state, so they stay put while op_req is up.
always_comb begin
    case (state)
        i2c_cfg_pkg::ST_START: op_o = i2c_cfg_pkg::OP_START;
        i2c_cfg_pkg::ST_STOP,
        i2c_cfg_pkg::ST_ABORT: op_o = i2c_cfg_pkg::OP_STOP;
        default:               op_o = i2c_cfg_pkg::OP_BYTE;
    endcase
    case (state)
        i2c_cfg_pkg::ST_ADDR: tx_byte_o = {dev_addr, 1'b0};  // write bit.
        i2c_cfg_pkg::ST_REG:  tx_byte_o = word_q[15:8];
        i2c_cfg_pkg::ST_DATA: tx_byte_o = word_q[7:0];
        default:              tx_byte_o = '0;
    endcase
end

always_ff @(posedge clock_76p8_mhz) begin
    if (state == i2c_cfg_pkg::ST_LOAD) begin
        word_q <= src_host ? host_word_i : init_word_i;
    end
end

always_ff @(posedge clock_76p8_mhz) begin
    if (reset_i) begin
        state        <= i2c_cfg_pkg::ST_IDLE;
        init_active  <= 1'b0;
        init_index_o <= '0;
        src_host     <= 1'b0;
        op_req_o     <= 1'b0;
        busy_o       <= 1'b0;
        nack_o       <= 1'b0;
    end else begin
        // a start during playback is dropped.
        if (init_start_i && !init_active) begin
            init_active  <= 1'b1;
            init_index_o <= '0;
        end

        case (state)
            i2c_cfg_pkg::ST_IDLE: begin
                if (host_pend_i || init_active || init_start_i) begin
                    src_host <= host_pend_i;        // host wins between transactions.
                    busy_o   <= 1'b1;
                    nack_o   <= 1'b0;
                    state    <= i2c_cfg_pkg::ST_LOAD;
                end
            end
            i2c_cfg_pkg::ST_LOAD: begin
                state <= i2c_cfg_pkg::ST_START;
            end
            default: begin
                // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                // one four-phase exchange per state
                // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                if (!op_req_o && !op_ack_i) begin
                    op_req_o <= 1'b1;
                end else if (op_done) begin
                    op_req_o <= 1'b0;
                    case (state)
                        i2c_cfg_pkg::ST_START: state <= i2c_cfg_pkg::ST_ADDR;
                        i2c_cfg_pkg::ST_ADDR:
                            state <= got_nack_i ? i2c_cfg_pkg::ST_ABORT : i2c_cfg_pkg::ST_REG;
                        i2c_cfg_pkg::ST_REG:
                            state <= got_nack_i ? i2c_cfg_pkg::ST_ABORT : i2c_cfg_pkg::ST_DATA;
                        i2c_cfg_pkg::ST_DATA:
                            state <= got_nack_i ? i2c_cfg_pkg::ST_ABORT : i2c_cfg_pkg::ST_STOP;
                        default: begin                  // stop done, transaction over.
                            state  <= i2c_cfg_pkg::ST_IDLE;
                            busy_o <= 1'b0;
                            if (state == i2c_cfg_pkg::ST_ABORT) begin
                                nack_o <= 1'b1;
                            end
                            if (!src_host && init_active) begin
                                if (init_index_o == 3'(i2c_cfg_pkg::INIT_COUNT - 1)) begin
                                    init_active <= 1'b0;
                                end else begin
                                    init_index_o <= init_index_o + 3'd1;
                                end
                            end
                        end
                    endcase
                end
            end
        endcase
    end
end

endmodule

//--- verilog/i2c_cfg_top.sv
`timescale 1ns/100ps

module i2c_cfg_top #(
    parameter int PRESCALE = 48
) (
    input  logic                  clock_76p8_mhz,
    input  logic                  reset_i,
    input  logic                  init_start_i,

    input  i2c_cfg_pkg::wb_addr_t wbs_adr_i,
    input  i2c_cfg_pkg::wb_data_t wbs_dat_i,
    input  logic                  wbs_we_i,
    input  logic                  wbs_stb_i,
    input  logic                  wbs_cyc_i,
    output logic                  wbs_ack_o,

    input  logic                  scl_i,
    output logic                  scl_o,
    output logic                  scl_t_o,
    input  logic                  sda_i,
    output logic                  sda_o,
    output logic                  sda_t_o,

    output logic                  busy_o,
    output logic                  nack_o
);

logic                      host_take;
logic                      host_pend;
i2c_cfg_pkg::cfg_word_t    host_word;
logic [2:0]                init_index;
i2c_cfg_pkg::cfg_word_t    init_word;
logic                      op_req;
i2c_cfg_pkg::shift_op_t    op;
i2c_cfg_pkg::i2c_byte_t    tx_byte;
logic                      op_ack;
logic                      got_nack;
logic                      tick_en;
logic                      tick;

// open drain, the pins only ever pull low.
assign scl_o = 1'b0;
assign sda_o = 1'b0;

i2c_host_port host_port_i (
    .clock_76p8_mhz (clock_76p8_mhz),
    .reset_i        (reset_i),
    .wbs_adr_i      (wbs_adr_i),
    .wbs_dat_i      (wbs_dat_i),
    .wbs_we_i       (wbs_we_i),
    .wbs_stb_i      (wbs_stb_i),
    .wbs_cyc_i      (wbs_cyc_i),
    .wbs_ack_o      (wbs_ack_o),
    .host_take_i    (host_take),
    .host_pend_o    (host_pend),
    .host_word_o    (host_word)
);

i2c_init_table init_table_i (
    .init_index_i (init_index),
    .init_word_o  (init_word)
);

i2c_txn_fsm txn_fsm_i (
    .clock_76p8_mhz (clock_76p8_mhz),
    .reset_i        (reset_i),
    .init_start_i   (init_start_i),
    .host_pend_i    (host_pend),
    .host_word_i    (host_word),
    .host_take_o    (host_take),
    .init_index_o   (init_index),
    .init_word_i    (init_word),
    .op_req_o       (op_req),
    .op_o           (op),
    .tx_byte_o      (tx_byte),
    .op_ack_i       (op_ack),
    .got_nack_i     (got_nack),
    .busy_o         (busy_o),
    .nack_o         (nack_o)
);

i2c_bit_timer #(
    .PRESCALE (PRESCALE)
) bit_timer_i (
    .clock_76p8_mhz (clock_76p8_mhz),
    .reset_i        (reset_i),
    .tick_en_i      (tick_en),
    .tick_o         (tick)
);

i2c_byte_shifter byte_shifter_i (
    .clock_76p8_mhz (clock_76p8_mhz),
    .reset_i        (reset_i),
    .op_req_i       (op_req),
    .op_i           (op),
    .tx_byte_i      (tx_byte),
    .op_ack_o       (op_ack),
    .got_nack_o     (got_nack),
    .tick_en_o      (tick_en),
    .tick_i         (tick),
    .scl_i          (scl_i),
    .scl_t_o        (scl_t_o),
    .sda_i          (sda_i),
    .sda_t_o        (sda_t_o)
);

endmodule

//--- tb/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h1a
) (
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_pull_o
);

logic        scl_q;
logic        sda_q;
logic        scl_high;
logic [7:0]  shreg;
logic [7:0]  addr_byte;
logic [7:0]  reg_byte;
logic [7:0]  data_byte;
logic        in_ack;
logic        addressed;
int          bit_cnt;
int          nbytes;
int          start_count = 0;
int          stop_count  = 0;
int          byte_count  = 0;
logic [23:0] log_q [$];                        // {pad, dev, reg, data} per complete write.

initial begin
    sda_pull_o = 1'b0;
    scl_q      = 1'b1;
    sda_q      = 1'b1;
    in_ack     = 1'b0;
    addressed  = 1'b0;
    bit_cnt    = 0;
    nbytes     = 0;
    shreg      = '0;
    forever begin
        @(scl_i or sda_i);
        scl_high = (scl_q === 1'b1) && (scl_i === 1'b1);
        if (scl_high && sda_q === 1'b1 && sda_i === 1'b0) begin
            start_count++;                      // start, a new transaction.
            bit_cnt   = 0;
            nbytes    = 0;
            in_ack    = 1'b0;
            addressed = 1'b0;
        end else if (scl_high && sda_q === 1'b0 && sda_i === 1'b1) begin
            stop_count++;
            if (addressed && nbytes == 3) begin
                log_q.push_back({1'b0, addr_byte[7:1], reg_byte, data_byte});
            end
        end else if (scl_q === 1'b0 && scl_i === 1'b1) begin
            if (bit_cnt < 8) begin
                shreg   = {shreg[6:0], sda_i};  // msb first.
                bit_cnt = bit_cnt + 1;
            end
        end else if (scl_q === 1'b1 && scl_i === 1'b0) begin
            if (in_ack) begin
                sda_pull_o = 1'b0;              // end of the ninth clock.
                in_ack     = 1'b0;
                bit_cnt    = 0;
            end else if (bit_cnt == 8) begin
                in_ack = 1'b1;
                byte_count++;
                case (nbytes)
                    0:       addr_byte = shreg;
                    1:       reg_byte  = shreg;
                    2:       data_byte = shreg;
                    default: ;
                endcase
                if (nbytes == 0) begin
                    addressed = (shreg == {DEV_ADDR, 1'b0});
                end
                nbytes     = nbytes + 1;
                sda_pull_o = addressed;         // silent when not addressed.
            end
        end
        scl_q = scl_i;
        sda_q = sda_i;
    end
end

endmodule

//--- tb/tb_i2c_cfg.sv
`timescale 1ns/100ps

module tb_i2c_cfg;

localparam int PRESCALE   = 4;
localparam int FIELDS     = 14;                 // columns per vector line.
localparam int NUM_TESTS  = 8;
localparam int IDX_W      = $clog2(NUM_TESTS * FIELDS);
localparam int TXN_CYCLES = 60 * 4 * PRESCALE;  // 60 bit times.

logic                  clock_76p8_mhz = 1'b0;
logic                  reset_i;
logic                  init_start_i;
i2c_cfg_pkg::wb_addr_t wbs_adr_i;
i2c_cfg_pkg::wb_data_t wbs_dat_i;
logic                  wbs_we_i;
logic                  wbs_stb_i;
logic                  wbs_cyc_i;
logic                  wbs_ack_o;
logic                  scl_t;
logic                  sda_t;
logic                  scl_o;
logic                  sda_o;
logic                  busy_o;
logic                  nack_o;
logic                  sda_pull;
wire                   scl_line = scl_t;
wire                   sda_line = sda_t & ~sda_pull;    // pull-up, either side pulls low.

logic [31:0] vec [0:NUM_TESTS*FIELDS-1];
int          seed            = 32'habc8df28;
int          error_count     = 0;
int          watchdog_cycles = 0;

always #5 clock_76p8_mhz = ~clock_76p8_mhz;

i2c_cfg_top #(
    .PRESCALE (PRESCALE)
) DUT (
    .clock_76p8_mhz (clock_76p8_mhz),
    .reset_i        (reset_i),
    .init_start_i   (init_start_i),
    .wbs_adr_i      (wbs_adr_i),
    .wbs_dat_i      (wbs_dat_i),
    .wbs_we_i       (wbs_we_i),
    .wbs_stb_i      (wbs_stb_i),
    .wbs_cyc_i      (wbs_cyc_i),
    .wbs_ack_o      (wbs_ack_o),
    .scl_i          (scl_line),
    .scl_o          (scl_o),
    .scl_t_o        (scl_t),
    .sda_i          (sda_line),
    .sda_o          (sda_o),
    .sda_t_o        (sda_t),
    .busy_o         (busy_o),
    .nack_o         (nack_o)
);

i2c_slave_model #(
    .DEV_ADDR (7'h1a)
) slave (
    .scl_i      (scl_line),
    .sda_i      (sda_line),
    .sda_pull_o (sda_pull)
);

function automatic logic [31:0] vector_field(input int test, input int col);
    return vec[IDX_W'(test * FIELDS + col)];
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("** Error at %0.1f ns: %s, got %h, expected %h", $realtime, what, got, exp);
        error_count++;
    end
endtask

task automatic next_cycle();
    @(posedge clock_76p8_mhz);
    #1;                                         // drive and sample just after the edge.
endtask

// cycles comes back 0 when no acknowledge arrived within limit.
task automatic host_write(input i2c_cfg_pkg::wb_addr_t adr, input logic [31:0] data,
                          input int limit, output int cycles);
    logic acked;
    wbs_adr_i = adr;
    wbs_dat_i = data;
    wbs_we_i  = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    cycles    = 0;
    acked     = 1'b0;
    while (!acked && cycles < limit) begin
        next_cycle();
        cycles++;
        acked = wbs_ack_o;
    end
    wbs_we_i  = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    if (!acked) begin
        cycles = 0;
    end
endtask

// a falling busy_o closes one transaction.
task automatic wait_txns(input int n);
    int   seen;
    int   cycles;
    logic prev;
    seen   = 0;
    cycles = 0;
    prev   = busy_o;
    while (seen < n && cycles < n * TXN_CYCLES) begin
        next_cycle();
        cycles++;
        if (prev && !busy_o) begin
            seen++;
        end
        prev = busy_o;
    end
    if (seen < n) begin
        $display("transaction %0d of %0d did not finish in time", seen + 1, n);
        error_count++;
    end
endtask

task automatic expect_triplet(input logic [23:0] exp);
    if (slave.log_q.size() == 0) begin
        $display("no write was logged on the bus where %h was expected", exp);
        error_count++;
    end else begin
        check_value(32'(slave.log_q.pop_front()), 32'(exp), "logged triplet");
    end
endtask

task automatic run_test(input int t, output string name);
    i2c_cfg_pkg::wb_addr_t adr;
    logic [31:0]           word;
    int                    cycles;
    int                    starts;
    int                    stops;
    int                    bytes;
    int                    i;
    adr    = 6'(vector_field(t, 1));
    starts = slave.start_count;
    stops  = slave.stop_count;
    bytes  = slave.byte_count;
    case (vector_field(t, 0))
        1: begin
            name         = "init playback";
            init_start_i = 1'b1;
            next_cycle();
            init_start_i = 1'b0;
            wait_txns(vector_field(t, 5));
            for (i = 0; i < vector_field(t, 5); i++) begin
                expect_triplet(24'(vector_field(t, 6 + i)));
            end
        end
        2: begin
            name = "host write";
            host_write(adr, vector_field(t, 2), 20, cycles);
            check_value(32'(cycles), 1, "ack latency");
            wait_txns(1);
            expect_triplet(24'(vector_field(t, 6)));
        end
        3: begin
            name = "ignored write";
            host_write(adr, vector_field(t, 2), 20, cycles);
            check_value(32'(cycles), 0, "ack on ignored write");
            check_value(32'(slave.start_count - starts), 0, "bus starts on ignored write");
        end
        4: begin
            name = "held-off write";
            host_write(adr, vector_field(t, 2), 20, cycles);
            check_value(32'(cycles), 1, "first ack latency");
            host_write(adr, vector_field(t, 3), 40, cycles);
            check_value(32'(cycles > 1), 1, "second ack held off");
            check_value(32'(busy_o), 1, "first request taken at second ack");
            wait_txns(2);
            expect_triplet(24'(vector_field(t, 6)));
            expect_triplet(24'(vector_field(t, 7)));
        end
        5: begin
            name = "missed ack";
            host_write(adr, vector_field(t, 2), 20, cycles);
            check_value(32'(cycles), 1, "ack latency");
            wait_txns(1);
            check_value(32'(nack_o), vector_field(t, 4), "nack after silent slave");
            check_value(32'(slave.start_count - starts), 1, "starts on nack");
            check_value(32'(slave.byte_count - bytes), 1, "bytes on nack");
            check_value(32'(slave.stop_count - stops), 1, "stops on nack");
            check_value(32'(slave.log_q.size()), 0, "writes logged on nack");
            host_write(adr, vector_field(t, 3), 20, cycles);
            wait_txns(1);
            expect_triplet(24'(vector_field(t, 6)));
        end
        6: begin
            name = "random writes";
            for (i = 0; i < vector_field(t, 5); i++) begin
                word = {8'h06, 8'h1a, 16'($random(seed))};
                host_write(adr, word, 20, cycles);
                check_value(32'(cycles), 1, "ack latency");
                wait_txns(1);
                expect_triplet({8'h1a, word[15:0]});    // device, reg and data as written.
            end
        end
        default: begin
            name = "unknown";
            $display("vector line %0d has unknown test kind %0d", t, vector_field(t, 0));
            error_count++;
        end
    endcase
    check_value(32'(busy_o), 0, "busy after test");
    check_value(32'(nack_o), 0, "nack after test");
    check_value(32'(scl_o), 0, "scl_o pin level");     // open drain, only ever low.
    check_value(32'(sda_o), 0, "sda_o pin level");
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
initial begin
    int    t;
    int    txns;
    int    errors_before;
    int    failed;
    string name;
    reset_i      = 1'b1;
    init_start_i = 1'b0;
    wbs_adr_i    = '0;
    wbs_dat_i    = '0;
    wbs_we_i     = 1'b0;
    wbs_stb_i    = 1'b0;
    wbs_cyc_i    = 1'b0;
    $readmemh("tb/i2c_cfg_vectors.txt", vec);
    txns = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
        txns += vector_field(t, 5) + 1;         // one spare per test.
    end
    watchdog_cycles = txns * TXN_CYCLES;
    repeat (4) @(posedge clock_76p8_mhz);
    #1;
    reset_i = 1'b0;
    next_cycle();
    failed = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
        errors_before = error_count;
        run_test(t, name);
        if (error_count != errors_before) begin
            failed++;
        end
        $display("test %0d %s: %s", t, name, (error_count == errors_before) ? "pass" : "fail");
    end
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed, error_count);
    if (error_count == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
end

initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clock_76p8_mhz);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
end

endmodule

//--- tb/i2c_cfg_vectors.txt
// all hex: kind adr word_a word_b nack count, then eight expected triplets (unused are 0)
// kind 1 init, 2 host write, 3 ignored write, 4 held-off pair, 5 missed ack, 6 random writes
1 00 00000000 00000000 0 8 1a1e00 1a0c10 1a0e02 1a1000 1a0812 1a0a00 1a0017 1a1201
2 3d 061a0455 00000000 0 1 1a0455 0 0 0 0 0 0 0
3 3c 061a0977 00000000 0 0 0 0 0 0 0 0 0 0
3 3d 051a0977 00000000 0 0 0 0 0 0 0 0 0 0
4 3d 061a0279 061a0480 0 2 1a0279 1a0480 0 0 0 0 0 0
5 3d 06551234 061a0c00 1 1 1a0c00 0 0 0 0 0 0 0
6 3d 00000000 00000000 0 0c 0 0 0 0 0 0 0 0
2 3d 061a0e01 00000000 0 1 1a0e01 0 0 0 0 0 0 0

//--- i2c_cfg_top.f
verilog/i2c_cfg_pkg.sv
verilog/i2c_init_table.sv
verilog/i2c_host_port.sv
verilog/i2c_bit_timer.sv
verilog/i2c_byte_shifter.sv
verilog/i2c_txn_fsm.sv
verilog/i2c_cfg_top.sv
tb/i2c_slave_model.sv
tb/tb_i2c_cfg.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_i2c_cfg
FILELIST  = i2c_cfg_top.f
BUILD     = obj_dir
LOG       = sim.log
PASS      = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS)$$" $(LOG) && echo "result: pass" || (echo "result: fail"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
